//--- common/ram_pkg.sv
/*
  Shared sizes and types for the on-chip RAM subsystem.
  Requesters, arbiter and RAM refer to these by scoped names.
*/

package ram_pkg;

  // Bank geometry of the 128 KB RAM
  localparam int RAM_BANKS  = 32;
  localparam int BANK_WORDS = 1024;
  localparam int BANK_AW    = 10;
  localparam int BANK_SW    = 5;
  localparam int RAM_AW     = BANK_SW + BANK_AW;

  // Data path
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  // Requesters sharing the RAM
  localparam int NUM_PORTS = 2;
  localparam int PORT_W    = 1;

  // Bank view of a word address
  typedef struct packed {
    logic [BANK_SW-1:0] bank;
    logic [BANK_AW-1:0] row;
  } ram_bank_row_t;

  // One address word, seen flat by the requesters and split by the RAM
  typedef union packed {
    logic [RAM_AW-1:0] word;
    ram_bank_row_t     bank_row;
  } ram_addr_u;

  // Request from one port
  // A non-zero wstrb is a write, zero is a read
  typedef struct packed {
    logic              req;
    ram_addr_u         addr;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
  } ram_req_t;

  // Single access issued to the RAM in a cycle
  typedef struct packed {
    logic              en;
    ram_addr_u         addr;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
  } ram_cmd_t;

  // Response back to one port
  typedef struct packed {
    logic              gnt;
    logic              rvalid;
    logic [DATA_W-1:0] rdata;
  } ram_rsp_t;

endpackage

//--- onchip_ram/onchip_ram.sv
/*
  128 KB on-chip RAM made of 32 SRAM macros of 4 KB each.
  Takes one command per cycle; read data appears one cycle later.
  The upper address bits pick the macro, the lower bits the row.
*/

`timescale 1ns/1ps

module onchip_ram (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  ram_pkg::ram_cmd_t          cmd_i,
  output logic [ram_pkg::DATA_W-1:0] rdata_o
);

  logic [ram_pkg::RAM_BANKS-1:0] bank_cs;
  logic                          wren;
  logic [ram_pkg::BANK_SW-1:0]   cmd_bank;
  logic [ram_pkg::BANK_AW-1:0]   cmd_row;
  logic [ram_pkg::DATA_W-1:0]    bank_rdata [ram_pkg::RAM_BANKS];
  logic [ram_pkg::BANK_SW-1:0]   rd_bank_q;

  assign cmd_bank = cmd_i.addr.bank_row.bank;
  assign cmd_row  = cmd_i.addr.bank_row.row;

  // Any strobe set makes it a write
  assign wren = |cmd_i.wstrb;

  // One-hot chip select
  always_comb begin
    bank_cs = '0;
    bank_cs[cmd_bank] = cmd_i.en;
  end

  // Remember which macro answers the read in flight
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rd_bank_q <= '0;
    end else if (cmd_i.en && !wren) begin
      rd_bank_q <= cmd_bank;
    end
  end

  for (genvar i = 0; i < ram_pkg::RAM_BANKS; i++) begin : gen_bank
    sram_1024x32 u_sram (
      .clk_i  (clk_i),
      .cs_i   (bank_cs[i]),
      .wren_i (wren),
      .addr_i (cmd_row),
      .data_i (cmd_i.wdata),
      .mask_i (cmd_i.wstrb),
      .data_o (bank_rdata[i])
    );
  end

  // Output mux uses the registered bank, not the current command
  assign rdata_o = bank_rdata[rd_bank_q];

endmodule

//--- onchip_ram/sram_1024x32.sv
/*
  Behavioral model of a single-port 1024x32 SRAM macro.
  Writes the bytes enabled by the mask and registers read data.
*/

`timescale 1ns/1ps

module sram_1024x32 (
  input  logic                        clk_i,
  input  logic                        cs_i,
  input  logic                        wren_i,
  input  logic [ram_pkg::BANK_AW-1:0] addr_i,
  input  logic [ram_pkg::DATA_W-1:0]  data_i,
  input  logic [ram_pkg::STRB_W-1:0]  mask_i,
  output logic [ram_pkg::DATA_W-1:0]  data_o
);

  // Storage array, contents undefined after power up
  logic [ram_pkg::DATA_W-1:0] mem [ram_pkg::BANK_WORDS];

  // Byte lane write
  always_ff @(posedge clk_i) begin
    if (cs_i && wren_i) begin
      for (int b = 0; b < ram_pkg::STRB_W; b++) begin
        if (mask_i[b]) begin
          mem[addr_i][b*8 +: 8] <= data_i[b*8 +: 8];
        end
      end
    end
  end

  // Read port, output holds until the next read
  always_ff @(posedge clk_i) begin
    if (cs_i && !wren_i) begin
      data_o <= mem[addr_i];
    end
  end

endmodule

//--- run.sh
#!/bin/sh
# Compile and run the RAM subsystem testbench with Verilator.
# Exit status is zero only when the testbench reports a pass.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_ram_subsys \
  -f vlog.f -o tb_ram_subsys \
  && ./obj_dir/tb_ram_subsys +verilator+error+limit+100 | tee /dev/stderr \
  | grep -q "TEST PASS" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

//--- test/ram_subsys_chk.sv
/*
  Protocol checker for the RAM subsystem, bound into the top level.
  Watches the grant and read-valid rules on both ports.
*/

`timescale 1ns/1ps

module ram_subsys_chk (
  input logic              clk_i,
  input logic              rst_n_i,
  input ram_pkg::ram_req_t req_i [ram_pkg::NUM_PORTS],
  input ram_pkg::ram_rsp_t rsp_i [ram_pkg::NUM_PORTS]
);

  // Number of failed assertions, read by the testbench at the end
  int fail_cnt = 0;

  // Quiet while in reset and in the first cycle after it
  a_reset_quiet: assert property (@(posedge clk_i)
    !rst_n_i |=> !(rsp_i[0].gnt || rsp_i[1].gnt || rsp_i[0].rvalid || rsp_i[1].rvalid))
    else begin
      $error("grant or read valid seen around reset");
      fail_cnt++;
    end

  // One access per cycle
  a_one_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0({rsp_i[1].gnt, rsp_i[0].gnt}))
    else begin
      $error("both ports granted in the same cycle");
      fail_cnt++;
    end

  for (genvar p = 0; p < ram_pkg::NUM_PORTS; p++) begin : gen_port
    a_gnt_has_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      rsp_i[p].gnt |-> req_i[p].req)
      else begin
        $error("port %0d granted without a request", p);
        fail_cnt++;
      end

    // A read grant returns data on the next cycle
    a_read_return: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (rsp_i[p].gnt && (req_i[p].wstrb == '0)) |=> rsp_i[p].rvalid)
      else begin
        $error("port %0d read grant not followed by rvalid", p);
        fail_cnt++;
      end

    a_rvalid_source: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      rsp_i[p].rvalid |-> $past(rsp_i[p].gnt && (req_i[p].wstrb == '0)))
      else begin
        $error("port %0d rvalid without a read grant one cycle before", p);
        fail_cnt++;
      end
  end

endmodule

bind ram_subsys_top ram_subsys_chk u_chk (
  .clk_i   (clk_i),
  .rst_n_i (rst_n_i),
  .req_i   (req_i),
  .rsp_i   (rsp_o)
);

//--- test/tb_ram_subsys.sv
/*
  Directed testbench for the shared on-chip RAM subsystem.
  Each test loads per-port access lists, runs them against the DUT
  and checks grants and read data against a word model.
*/

`timescale 1ns/1ps

module tb_ram_subsys;

  localparam int MAX_OPS = 128;
  // All tests together take a few hundred cycles, this leaves ample margin
  localparam int TIMEOUT_CYCLES = 2000;

  logic              clk_i = 1'b0;
  logic              rst_n_i = 1'b0;
  ram_pkg::ram_req_t req [ram_pkg::NUM_PORTS];
  ram_pkg::ram_rsp_t rsp [ram_pkg::NUM_PORTS];

  // Access lists and expected read data per port
  ram_pkg::ram_req_t op_mem [ram_pkg::NUM_PORTS][MAX_OPS];
  int                op_cnt [ram_pkg::NUM_PORTS];
  int                op_idx [ram_pkg::NUM_PORTS];
  int                start_cyc [ram_pkg::NUM_PORTS];
  logic [31:0]       exp_mem [ram_pkg::NUM_PORTS][MAX_OPS];
  int                exp_wr [ram_pkg::NUM_PORTS];
  int                exp_rd [ram_pkg::NUM_PORTS];
  logic              rd_due [ram_pkg::NUM_PORTS];
  logic              driven [ram_pkg::NUM_PORTS];
  int                gnt_log [2*MAX_OPS];
  int                gnt_cnt;
  int                run_cycles;

  // Word model of the RAM, keyed by word address
  logic [31:0]       model [int];
  logic [14:0]       saved_addr [16];

  integer            seed = 32'he4f;
  int                cycle_cnt = 0;
  int                err_cnt = 0;
  int                test_cnt = 0;
  int                pass_cnt = 0;
  int                test_err0;
  string             test_name;

  ram_subsys_top DUT (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (req),
    .rsp_o   (rsp)
  );

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Run timed out after %0d cycles", cycle_cnt);
      $display("TEST FAIL");
      $finish;
    end
  end

  function automatic int total_errors();
    return err_cnt + DUT.u_chk.fail_cnt;
  endfunction

  task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("Error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0]  strb);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < ram_pkg::STRB_W; b++) begin
      if (strb[b]) begin
        res[b*8 +: 8] = new_w[b*8 +: 8];
      end
    end
    return res;
  endfunction

  task automatic clear_ops();
    for (int p = 0; p < ram_pkg::NUM_PORTS; p++) begin
      op_cnt[p] = 0;
      op_idx[p] = 0;
      start_cyc[p] = 0;
      exp_wr[p] = 0;
      exp_rd[p] = 0;
      rd_due[p] = 1'b0;
    end
    gnt_cnt = 0;
  endtask

  task automatic add_op(input int p, input logic [14:0] addr, input logic [31:0] wdata,
                        input logic [3:0] wstrb);
    ram_pkg::ram_req_t op;
    op.req = 1'b1;
    op.addr.word = addr;
    op.wdata = wdata;
    op.wstrb = wstrb;
    op_mem[p][op_cnt[p]] = op;
    op_cnt[p]++;
  endtask

  function automatic ram_pkg::ram_req_t next_req(input int p);
    if (op_idx[p] < op_cnt[p] && run_cycles >= start_cyc[p]) begin
      return op_mem[p][op_idx[p]];
    end
    return '0;
  endfunction

  // Accepted access updates the model or queues the expected read data
  task automatic apply_grant(input int p);
    ram_pkg::ram_req_t op;
    int                key;
    logic [31:0]       old_w;
    op = op_mem[p][op_idx[p]];
    key = int'(op.addr.word);
    if (op.wstrb != '0) begin
      old_w = model.exists(key) ? model[key] : '0;
      model[key] = merge_bytes(old_w, op.wdata, op.wstrb);
    end else begin
      exp_mem[p][exp_wr[p]] = model[key];
      exp_wr[p]++;
      rd_due[p] = 1'b1;
    end
    op_idx[p]++;
    gnt_log[gnt_cnt] = p;
    gnt_cnt++;
  endtask

  // Drive both ports cycle by cycle until every access is granted and returned
  task automatic run_ops();
    logic              busy;
    ram_pkg::ram_req_t nxt [ram_pkg::NUM_PORTS];
    run_cycles = 0;
    busy = 1'b1;
    while (busy) begin
      @(posedge clk_i);
      nxt[0] = next_req(0);
      nxt[1] = next_req(1);
      req[0] <= nxt[0];
      req[1] <= nxt[1];
      driven[0] = nxt[0].req;
      driven[1] = nxt[1].req;
      @(negedge clk_i);
      run_cycles++;
      busy = 1'b0;
      for (int p = 0; p < ram_pkg::NUM_PORTS; p++) begin
        check_val(32'(rsp[p].rvalid), 32'(rd_due[p]), $sformatf("port %0d rvalid timing", p));
        if (rsp[p].rvalid && exp_rd[p] < exp_wr[p]) begin
          check_val(rsp[p].rdata, exp_mem[p][exp_rd[p]], $sformatf("port %0d read data", p));
          exp_rd[p]++;
        end
        rd_due[p] = 1'b0;
        if (rsp[p].gnt && !driven[p]) begin
          $display("Port %0d was granted while it had no request", p);
          err_cnt++;
        end else if (rsp[p].gnt) begin
          apply_grant(p);
        end
        busy = busy || rd_due[p] || (op_idx[p] < op_cnt[p]);
      end
    end
    @(posedge clk_i);
    req[0] <= '0;
    req[1] <= '0;
  endtask

  task automatic apply_reset();
    rst_n_i <= 1'b0;
    repeat (3) @(posedge clk_i);
    rst_n_i <= 1'b1;
  endtask

  task automatic open_test(input string name);
    test_name = name;
    test_err0 = total_errors();
  endtask

  task automatic close_test();
    test_cnt++;
    if (total_errors() == test_err0) begin
      pass_cnt++;
      $display("%s: passed", test_name);
    end else begin
      $display("%s: failed with %0d errors", test_name, total_errors() - test_err0);
    end
  endtask

  task automatic test_write_read();
    open_test("single port write and read");
    clear_ops();
    for (int i = 0; i < 16; i++) begin
      saved_addr[i] = 15'($random(seed));
      add_op(0, saved_addr[i], $random(seed), 4'hf);
    end
    run_ops();
    clear_ops();
    for (int i = 0; i < 16; i++) begin
      add_op(0, saved_addr[i], '0, 4'h0);
    end
    run_ops();
    close_test();
  endtask

  task automatic test_byte_strobes();
    logic [14:0] a;
    open_test("byte strobes");
    clear_ops();
    a = 15'($random(seed));
    add_op(1, a, $random(seed), 4'hf);
    add_op(1, a, '0, 4'h0);
    for (int b = 0; b < ram_pkg::STRB_W; b++) begin
      add_op(1, a, $random(seed), 4'(1 << b));
      add_op(1, a, '0, 4'h0);
    end
    run_ops();
    close_test();
  endtask

  task automatic test_bank_decode();
    logic [4:0]  bank;
    logic [9:0]  row;
    int          p;
    open_test("bank decode");
    clear_ops();
    for (int pass = 0; pass < 2; pass++) begin
      for (int b = 0; b < ram_pkg::RAM_BANKS; b++) begin
        for (int r = 0; r < 2; r++) begin
          bank = 5'(b);
          row = (r == 0) ? 10'd0 : 10'd1023;
          p = (b < 16) ? 0 : 1;
          // Value tags the bank and row so aliasing shows as a mismatch
          if (pass == 0) begin
            add_op(p, {bank, row}, {8'hb5, 3'b000, bank, 6'b000000, row}, 4'hf);
          end else begin
            add_op(p, {bank, row}, '0, 4'h0);
          end
        end
      end
    end
    run_ops();
    close_test();
  endtask

  task automatic test_contention();
    logic [14:0] a [2][4];
    logic [14:0] pre_addr;
    open_test("contention");
    // A lone port 0 write leaves the priority with port 1 before the reset
    clear_ops();
    pre_addr = 15'($random(seed));
    add_op(0, pre_addr, $random(seed), 4'hf);
    run_ops();
    apply_reset();
    clear_ops();
    for (int p = 0; p < ram_pkg::NUM_PORTS; p++) begin
      for (int i = 0; i < 4; i++) begin
        a[p][i] = 15'($random(seed));
        add_op(p, a[p][i], $random(seed), 4'hf);
      end
      for (int i = 0; i < 4; i++) begin
        add_op(p, a[p][i], '0, 4'h0);
      end
    end
    run_ops();
    check_val(32'(gnt_cnt), 32'd16, "contention grant count");
    for (int i = 0; i < gnt_cnt; i++) begin
      check_val(32'(gnt_log[i]), 32'(i % 2), $sformatf("grant %0d port", i));
    end
    close_test();
  endtask

  task automatic test_pipelined_reads();
    open_test("pipelined reads");
    clear_ops();
    for (int i = 0; i < 8; i++) begin
      add_op(0, saved_addr[i], '0, 4'h0);
    end
    run_ops();
    // One grant per cycle plus the last return cycle
    check_val(32'(run_cycles), 32'd9, "pipelined read cycles");
    close_test();
  endtask

  task automatic test_cross_port();
    open_test("cross port ordering");
    clear_ops();
    for (int i = 0; i < 4; i++) begin
      add_op(1, saved_addr[8+i], $random(seed), 4'hf);
      add_op(0, saved_addr[8+i], '0, 4'h0);
    end
    start_cyc[0] = 1;
    run_ops();
    for (int i = 0; i < gnt_cnt; i++) begin
      check_val(32'(gnt_log[i]), 32'((i % 2 == 0) ? 1 : 0), $sformatf("grant %0d port", i));
    end
    close_test();
  endtask

  initial begin
    req[0] = '0;
    req[1] = '0;
    apply_reset();
    test_write_read();
    test_byte_strobes();
    test_bank_decode();
    test_contention();
    test_pipelined_reads();
    test_cross_port();
    $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
             test_cnt, pass_cnt, test_cnt - pass_cnt, total_errors());
    if (total_errors() == 0 && pass_cnt == test_cnt) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- verilog/ram_arbiter.sv
/*
  Round-robin arbiter between the processor port and the DMA port.
  Grants one access per cycle and forwards it as the RAM command.
  Read data is routed back with rvalid one cycle after the grant.
*/

`timescale 1ns/1ps

module ram_arbiter (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  ram_pkg::ram_req_t          req_i [ram_pkg::NUM_PORTS],
  output ram_pkg::ram_rsp_t          rsp_o [ram_pkg::NUM_PORTS],
  output ram_pkg::ram_cmd_t          cmd_o,
  input  logic [ram_pkg::DATA_W-1:0] rdata_i
);

  logic [ram_pkg::NUM_PORTS-1:0] req_vec;
  logic [ram_pkg::NUM_PORTS-1:0] gnt;
  logic                          any_req;
  logic [ram_pkg::PORT_W-1:0]    win;
  logic                          win_is_read;

  // Port that wins a tie
  logic [ram_pkg::PORT_W-1:0]    prio_q;

  // Read return record
  logic                          rd_pend_q;
  logic [ram_pkg::PORT_W-1:0]    rd_port_q;

  always_comb begin
    for (int p = 0; p < ram_pkg::NUM_PORTS; p++) begin
      req_vec[p] = req_i[p].req;
    end
  end

  assign any_req = |req_vec;

  // Winner selection
  // a lone requester always wins, a tie goes to the priority port
  always_comb begin
    if (&req_vec) begin
      win = prio_q;
    end else if (req_vec[1]) begin
      win = 1'b1;
    end else begin
      win = 1'b0;
    end
  end

  always_comb begin
    for (int p = 0; p < ram_pkg::NUM_PORTS; p++) begin
      gnt[p] = any_req && (win == p[ram_pkg::PORT_W-1:0]);
    end
  end

  // Forward the winning request
  always_comb begin
    cmd_o.en    = any_req;
    cmd_o.addr  = req_i[win].addr;
    cmd_o.wdata = req_i[win].wdata;
    cmd_o.wstrb = req_i[win].wstrb;
  end

  assign win_is_read = (req_i[win].wstrb == '0);

  // Priority moves to the other port after every grant
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      prio_q <= '0;
    end else if (any_req) begin
      prio_q <= ~win;
    end
  end

  // Track the granted read so its data goes back to the right port
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rd_pend_q <= 1'b0;
      rd_port_q <= '0;
    end else begin
      rd_pend_q <= any_req && win_is_read;
      if (any_req && win_is_read) begin
        rd_port_q <= win;
      end
    end
  end

  always_comb begin
    for (int p = 0; p < ram_pkg::NUM_PORTS; p++) begin
      rsp_o[p].gnt    = gnt[p];
      rsp_o[p].rvalid = rd_pend_q && (rd_port_q == p[ram_pkg::PORT_W-1:0]);
      // Both ports see the data, rvalid says whose it is
      rsp_o[p].rdata  = rdata_i;
    end
  end

endmodule

//--- verilog/ram_subsys_top.sv
/*
  Top level of the shared RAM subsystem.
  Port 0 is the processor data port, port 1 the DMA port.
  Each port drives a request struct and gets a response struct back.
*/

`timescale 1ns/1ps

module ram_subsys_top (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  ram_pkg::ram_req_t req_i [ram_pkg::NUM_PORTS],
  output ram_pkg::ram_rsp_t rsp_o [ram_pkg::NUM_PORTS]
);

  // Access chosen by the arbiter this cycle
  ram_pkg::ram_cmd_t          ram_cmd;

  // Read data from the bank that answered last cycle
  logic [ram_pkg::DATA_W-1:0] ram_rdata;

  ram_arbiter u_arbiter (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (req_i),
    .rsp_o   (rsp_o),
    .cmd_o   (ram_cmd),
    .rdata_i (ram_rdata)
  );

  onchip_ram u_ram (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .cmd_i   (ram_cmd),
    .rdata_o (ram_rdata)
  );

endmodule

//--- vlog.f
common/ram_pkg.sv
onchip_ram/sram_1024x32.sv
onchip_ram/onchip_ram.sv
verilog/ram_arbiter.sv
verilog/ram_subsys_top.sv
test/ram_subsys_chk.sv
test/tb_ram_subsys.sv
